/* all.f */
+incdir+logic
+incdir+tests
logic/mci_pkg.sv
logic/mci_wdt.sv
logic/mci_err_status.sv
logic/mci_err_agg.sv
logic/mci_err_top.sv
tests/mci_err_top_tb.sv

/* Makefile */
# Verilator build and run of the error reporting testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := mci_err_top_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := logic/mci_config.svh tests/mci_err_tests.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/mci_err_tests.svh */
`ifndef MCI_ERR_TESTS_SVH
`define MCI_ERR_TESTS_SVH

// The zero check runs on the first falling edge after reset release
task automatic reset_values();
  begin_test("reset_values");
  @(negedge core_clk);
  step();
  end_test();
endtask

task automatic pulse_unmasked();
  logic is_fatal;
  int   idx;
  int   sel;
  begin_test("pulse_unmasked");
  repeat (4) begin
    is_fatal = (random_bits(1) == 32'd1);
    idx      = int'(random_bits(2));
    sel      = is_fatal ? sel_all_fatal : sel_all_non_fatal;
    step();
    if (is_fatal) begin
      fatal_src[idx] = 1'b1;
    end else begin
      non_fatal_src[idx] = 1'b1;
    end
    step();
    fatal_src     = '0;
    non_fatal_src = '0;
    wait_level(sel, 1'b1, 6, "aggregated output");
    idle(2);
    if (is_fatal) begin
      fatal_clr.ext[idx] = 1'b1;
    end else begin
      non_fatal_clr.ext[idx] = 1'b1;
    end
    step();
    fatal_clr     = '0;
    non_fatal_clr = '0;
    wait_level(sel, 1'b0, 6, "aggregated output after clear");
  end
  end_test();
endtask

// The status bit is still captured while the summary is held low
task automatic pulse_masked();
  int idx;
  begin_test("pulse_masked");
  repeat (4) begin
    idx = int'(random_bits(2));
    step();
    fatal_mask.ext[idx]     = 1'b1;
    non_fatal_mask.ext[idx] = 1'b1;
    fatal_src[idx]          = 1'b1;
    non_fatal_src[idx]      = 1'b1;
    step();
    fatal_src     = '0;
    non_fatal_src = '0;
    idle(5);
    fatal_clr.ext[idx]     = 1'b1;
    non_fatal_clr.ext[idx] = 1'b1;
    step();
    fatal_clr     = '0;
    non_fatal_clr = '0;
    idle(2);
    fatal_mask     = '0;
    non_fatal_mask = '0;
  end
  end_test();
endtask

task automatic cascade_watchdog();
  int p1;
  int p2;
  int half;
  begin_test("cascade_watchdog");
  p1   = 4 + int'(random_bits(4));
  p2   = 4 + int'(random_bits(4));
  half = p1 / 2;
  step();
  timer1_period = mci_pkg::wdt_cnt_t'(p1);
  timer2_period = mci_pkg::wdt_cnt_t'(p2);
  timer2_en     = 1'b0;
  timer1_en     = 1'b1;
  wait_level(sel_wdt_t1, 1'b1, p1 + 8, "non-fatal wdt_t1 status");
  wait_level(sel_wdt_t2, 1'b1, p2 + 8, "fatal wdt_t2 status");
  step();
  timer1_en  = 1'b0;
  t1_service = 1'b1;
  t2_service = 1'b1;
  step();
  t1_service           = 1'b0;
  t2_service           = 1'b0;
  fatal_clr.wdt_t2     = 1'b1;
  non_fatal_clr.wdt_t1 = 1'b1;
  step();
  fatal_clr     = '0;
  non_fatal_clr = '0;
  wait_level(sel_all_fatal, 1'b0, 6, "all_error_fatal after service");
  wait_level(sel_all_non_fatal, 1'b0, 6, "all_error_non_fatal after service");
  // Pets at half the period keep timer 1 short of expiry
  step();
  timer1_en = 1'b1;
  for (int i = 0; i < 4 * p1; i++) begin
    timer1_restart = (i % half == 0);
    step();
  end
  timer1_restart = 1'b0;
  timer1_en      = 1'b0;
  t1_service     = 1'b1;
  step();
  t1_service = 1'b0;
  end_test();
endtask

task automatic independent_watchdog();
  int p1;
  int p2;
  begin_test("independent_watchdog");
  p1 = 4 + int'(random_bits(4));
  p2 = 4 + int'(random_bits(4));
  step();
  timer1_period = mci_pkg::wdt_cnt_t'(p1);
  timer2_period = mci_pkg::wdt_cnt_t'(p2);
  timer1_en     = 1'b1;
  timer2_en     = 1'b1;
  for (int round = 0; round < 2; round++) begin
    wait_level(sel_wdt_t1, 1'b1, 40, "non-fatal wdt_t1 status");
    wait_level(sel_wdt_t2, 1'b1, 40, "fatal wdt_t2 status");
    // Pets during a timeout are dropped, so a clear right after finds it still set
    step();
    timer1_restart = 1'b1;
    timer2_restart = 1'b1;
    step();
    timer1_restart       = 1'b0;
    timer2_restart       = 1'b0;
    fatal_clr.wdt_t2     = 1'b1;
    non_fatal_clr.wdt_t1 = 1'b1;
    step();
    fatal_clr     = '0;
    non_fatal_clr = '0;
    idle(3);
    t1_service = 1'b1;
    t2_service = 1'b1;
    if (round == 1) begin
      timer1_en = 1'b0;
      timer2_en = 1'b0;
    end
    step();
    t1_service           = 1'b0;
    t2_service           = 1'b0;
    fatal_clr.wdt_t2     = 1'b1;
    non_fatal_clr.wdt_t1 = 1'b1;
    step();
    fatal_clr     = '0;
    non_fatal_clr = '0;
  end
  wait_level(sel_all_fatal, 1'b0, 6, "all_error_fatal after service");
  wait_level(sel_all_non_fatal, 1'b0, 6, "all_error_non_fatal after service");
  end_test();
endtask

`endif

/* tests/mci_err_top_tb.sv */
`timescale 1ns/1ps

`include "mci_config.svh"

module mci_err_top_tb;

  // Signal selectors for wait_level
  localparam int sel_all_fatal     = 0;
  localparam int sel_all_non_fatal = 1;
  localparam int sel_wdt_t1        = 2;
  localparam int sel_wdt_t2        = 3;

  logic                              core_clk = 1'b0;
  logic                              rst_n;
  logic                              timer1_en;
  logic                              timer2_en;
  logic                              timer1_restart;
  logic                              timer2_restart;
  logic                              t1_service;
  logic                              t2_service;
  mci_pkg::wdt_cnt_t                 timer1_period;
  mci_pkg::wdt_cnt_t                 timer2_period;
  logic [`MCI_NUM_FATAL_EXT-1:0]     fatal_src;
  logic [`MCI_NUM_NON_FATAL_EXT-1:0] non_fatal_src;
  mci_pkg::hw_err_fatal_t            fatal_clr;
  mci_pkg::hw_err_fatal_t            fatal_mask;
  mci_pkg::hw_err_non_fatal_t        non_fatal_clr;
  mci_pkg::hw_err_non_fatal_t        non_fatal_mask;
  mci_pkg::hw_err_fatal_t            hw_error_fatal;
  mci_pkg::hw_err_non_fatal_t        hw_error_non_fatal;
  logic                              all_error_fatal;
  logic                              all_error_non_fatal;

  string       test_name       = "startup";
  int          test_count      = 0;
  int          check_count     = 0;
  int          check_errors    = 0;
  int          flow_errors     = 0;
  int          errors_at_start = 0;
  logic        checks_on       = 1'b0;
  logic [31:0] lfsr_state      = 32'hb8fec1a5;

  always #2 core_clk = ~core_clk;

  mci_err_top mci_err_top_inst (
    .core_clk_i            (core_clk),
    .rst_n_i               (rst_n),
    .timer1_en_i           (timer1_en),
    .timer2_en_i           (timer2_en),
    .timer1_restart_i      (timer1_restart),
    .timer2_restart_i      (timer2_restart),
    .t1_service_i          (t1_service),
    .t2_service_i          (t2_service),
    .timer1_period_i       (timer1_period),
    .timer2_period_i       (timer2_period),
    .fatal_src_i           (fatal_src),
    .non_fatal_src_i       (non_fatal_src),
    .fatal_clr_i           (fatal_clr),
    .fatal_mask_i          (fatal_mask),
    .non_fatal_clr_i       (non_fatal_clr),
    .non_fatal_mask_i      (non_fatal_mask),
    .hw_error_fatal_o      (hw_error_fatal),
    .hw_error_non_fatal_o  (hw_error_non_fatal),
    .all_error_fatal_o     (all_error_fatal),
    .all_error_non_fatal_o (all_error_non_fatal)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  int unsigned                m_cnt1;
  int unsigned                m_cnt2;
  logic                       m_to1;
  logic                       m_to2;
  logic                       t1_counting;
  logic                       t2_counting;
  mci_pkg::hw_err_fatal_t     m_fatal;
  mci_pkg::hw_err_non_fatal_t m_non_fatal;
  logic [1:0]                 m_any_q;
  logic [1:0]                 m_all_q;

  // Timer 2 runs freely when enabled and otherwise only behind an expired timer 1
  assign t1_counting = timer1_en && !m_to1;
  assign t2_counting = (timer2_en || (timer1_en && m_to1)) && !m_to2;

  // Bit 1 of the summary pipes is fatal and bit 0 is non-fatal
  always @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_cnt1      <= 0;
      m_cnt2      <= 0;
      m_to1       <= 1'b0;
      m_to2       <= 1'b0;
      m_fatal     <= '0;
      m_non_fatal <= '0;
      m_any_q     <= '0;
      m_all_q     <= '0;
    end else begin
      if (t1_service || (timer1_restart && !m_to1)) begin
        m_cnt1 <= 0;
      end else if (t1_counting) begin
        m_cnt1 <= m_cnt1 + 1;
      end
      if (t2_service || (timer2_restart && !m_to2)) begin
        m_cnt2 <= 0;
      end else if (t2_counting) begin
        m_cnt2 <= m_cnt2 + 1;
      end
      if (t1_service) begin
        m_to1 <= 1'b0;
      end else if (t1_counting && m_cnt1 == 32'(timer1_period)) begin
        m_to1 <= 1'b1;
      end
      if (t2_service) begin
        m_to2 <= 1'b0;
      end else if (t2_counting && m_cnt2 == 32'(timer2_period)) begin
        m_to2 <= 1'b1;
      end
      m_fatal     <= mci_pkg::hw_err_fatal_t'((m_fatal & ~fatal_clr) | {m_to2, fatal_src});
      m_non_fatal <= mci_pkg::hw_err_non_fatal_t'((m_non_fatal & ~non_fatal_clr) |
                                                  {m_to1, non_fatal_src});
      m_any_q     <= {|(m_fatal & ~fatal_mask), |(m_non_fatal & ~non_fatal_mask)};
      m_all_q     <= m_any_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
  endtask

  // Outputs have settled by the falling edge, half a cycle after any input change
  always @(negedge core_clk) begin
    if (checks_on) begin
      check_count = check_count + 4;
    end
  end

  a_fatal_status: assert property (@(negedge core_clk) disable iff (!checks_on)
                                   hw_error_fatal == m_fatal)
    else begin
      check_errors++;
      report_mismatch("fatal status", {11'b0, m_fatal}, {11'b0, hw_error_fatal});
    end

  a_non_fatal_status: assert property (@(negedge core_clk) disable iff (!checks_on)
                                       hw_error_non_fatal == m_non_fatal)
    else begin
      check_errors++;
      report_mismatch("non-fatal status", {11'b0, m_non_fatal}, {11'b0, hw_error_non_fatal});
    end

  a_all_fatal: assert property (@(negedge core_clk) disable iff (!checks_on)
                                all_error_fatal == m_all_q[1])
    else begin
      check_errors++;
      report_mismatch("all_error_fatal", {15'b0, m_all_q[1]}, {15'b0, all_error_fatal});
    end

  a_all_non_fatal: assert property (@(negedge core_clk) disable iff (!checks_on)
                                    all_error_non_fatal == m_all_q[0])
    else begin
      check_errors++;
      report_mismatch("all_error_non_fatal", {15'b0, m_all_q[0]},
                      {15'b0, all_error_non_fatal});
    end

  // Everything reads zero on the first falling edge after reset release
  a_reset_zero: assert property (@(negedge core_clk) $rose(rst_n) |->
                                 (hw_error_fatal == '0 && hw_error_non_fatal == '0 &&
                                  !all_error_fatal && !all_error_non_fatal))
    else begin
      check_errors++;
      report_mismatch("outputs after reset", 16'h0000,
                      {4'b0, hw_error_fatal, hw_error_non_fatal, all_error_fatal,
                       all_error_non_fatal});
    end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned random_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | {31'b0, lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic probe_level(input int sel);
    case (sel)
      sel_all_fatal:     return all_error_fatal;
      sel_all_non_fatal: return all_error_non_fatal;
      sel_wdt_t1:        return hw_error_non_fatal.wdt_t1;
      default:           return hw_error_fatal.wdt_t2;
    endcase
  endfunction

  task automatic step();
    @(posedge core_clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what);
    int waited;
    waited = 0;
    @(negedge core_clk);
    while (probe_level(sel) !== level && waited < limit) begin
      @(negedge core_clk);
      waited++;
    end
    if (probe_level(sel) !== level) begin
      flow_errors++;
      $display("%s: %s did not reach %0b within %0d cycles", test_name, what, level, limit);
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = check_errors + flow_errors;
  endtask

  task automatic end_test();
    int errs;
    errs = check_errors + flow_errors - errors_at_start;
    test_count++;
    if (errs == 0) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, errs);
    end
  endtask

  `include "mci_err_tests.svh"

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    timer1_en      = 1'b0;
    timer2_en      = 1'b0;
    timer1_restart = 1'b0;
    timer2_restart = 1'b0;
    t1_service     = 1'b0;
    t2_service     = 1'b0;
    timer1_period  = '0;
    timer2_period  = '0;
    fatal_src      = '0;
    non_fatal_src  = '0;
    fatal_clr      = '0;
    fatal_mask     = '0;
    non_fatal_clr  = '0;
    non_fatal_mask = '0;
    repeat (8) @(posedge core_clk);
    #1;
    rst_n     = 1'b1;
    checks_on = 1'b1;
    reset_values();
    pulse_unmasked();
    pulse_masked();
    cascade_watchdog();
    independent_watchdog();
    idle(4);
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count,
             check_errors + flow_errors);
    if (check_errors + flow_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Hard stop in case a wait never returns
  initial begin
    #100000;
    $display("simulation time limit reached in %s", test_name);
    $display("Test failed");
    $finish;
  end

endmodule

/* logic/mci_err_top.sv */
`timescale 1ns/1ps

`include "mci_config.svh"

module mci_err_top (
  input  logic                              core_clk_i,
  input  logic                              rst_n_i,

  // Watchdog controls
  input  logic                              timer1_en_i,
  input  logic                              timer2_en_i,
  input  logic                              timer1_restart_i,
  input  logic                              timer2_restart_i,
  input  logic                              t1_service_i,
  input  logic                              t2_service_i,
  input  mci_pkg::wdt_cnt_t                 timer1_period_i,
  input  mci_pkg::wdt_cnt_t                 timer2_period_i,

  // External hardware error sources
  input  logic [`MCI_NUM_FATAL_EXT-1:0]     fatal_src_i,
  input  logic [`MCI_NUM_NON_FATAL_EXT-1:0] non_fatal_src_i,

  // Software side of the status registers
  input  mci_pkg::hw_err_fatal_t            fatal_clr_i,
  input  mci_pkg::hw_err_fatal_t            fatal_mask_i,
  input  mci_pkg::hw_err_non_fatal_t        non_fatal_clr_i,
  input  mci_pkg::hw_err_non_fatal_t        non_fatal_mask_i,

  output mci_pkg::hw_err_fatal_t            hw_error_fatal_o,
  output mci_pkg::hw_err_non_fatal_t        hw_error_non_fatal_o,

  // Aggregated summary outputs
  output logic                              all_error_fatal_o,
  output logic                              all_error_non_fatal_o
);

  logic                       t1_timeout;
  logic                       t2_timeout;
  mci_pkg::hw_err_fatal_t     fatal_src;
  mci_pkg::hw_err_non_fatal_t non_fatal_src;
  mci_pkg::hw_err_fatal_t     fatal_status;
  mci_pkg::hw_err_non_fatal_t non_fatal_status;

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  mci_wdt mci_wdt_inst (
    .core_clk_i       (core_clk_i),
    .rst_n_i          (rst_n_i),
    .timer1_en_i      (timer1_en_i),
    .timer2_en_i      (timer2_en_i),
    .timer1_restart_i (timer1_restart_i),
    .timer2_restart_i (timer2_restart_i),
    .t1_service_i     (t1_service_i),
    .t2_service_i     (t2_service_i),
    .timer1_period_i  (timer1_period_i),
    .timer2_period_i  (timer2_period_i),
    .t1_timeout_o     (t1_timeout),
    .t2_timeout_o     (t2_timeout)
  );

  //////////////////////////////////////////////////////////////////////
  // Error status registers
  //////////////////////////////////////////////////////////////////////

  // Timer 1 expiry is non-fatal and timer 2 expiry is fatal
  assign fatal_src.wdt_t2     = t2_timeout;
  assign fatal_src.ext        = fatal_src_i;
  assign non_fatal_src.wdt_t1 = t1_timeout;
  assign non_fatal_src.ext    = non_fatal_src_i;

  mci_err_status #(
    .err_t (mci_pkg::hw_err_fatal_t)
  ) fatal_status_inst (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .src_i      (fatal_src),
    .clr_i      (fatal_clr_i),
    .status_o   (fatal_status)
  );

  mci_err_status #(
    .err_t (mci_pkg::hw_err_non_fatal_t)
  ) non_fatal_status_inst (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .src_i      (non_fatal_src),
    .clr_i      (non_fatal_clr_i),
    .status_o   (non_fatal_status)
  );

  assign hw_error_fatal_o     = fatal_status;
  assign hw_error_non_fatal_o = non_fatal_status;

  //////////////////////////////////////////////////////////////////////
  // Aggregation
  //////////////////////////////////////////////////////////////////////

  mci_err_agg mci_err_agg_inst (
    .core_clk_i            (core_clk_i),
    .rst_n_i               (rst_n_i),
    .fatal_status_i        (fatal_status),
    .fatal_mask_i          (fatal_mask_i),
    .non_fatal_status_i    (non_fatal_status),
    .non_fatal_mask_i      (non_fatal_mask_i),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o)
  );

endmodule

/* logic/mci_err_agg.sv */
`timescale 1ns/1ps

module mci_err_agg (
  input  logic                       core_clk_i,
  input  logic                       rst_n_i,

  input  mci_pkg::hw_err_fatal_t     fatal_status_i,
  input  mci_pkg::hw_err_fatal_t     fatal_mask_i,

  input  mci_pkg::hw_err_non_fatal_t non_fatal_status_i,
  input  mci_pkg::hw_err_non_fatal_t non_fatal_mask_i,

  output logic                       all_error_fatal_o,
  output logic                       all_error_non_fatal_o
);

  logic fatal_any;
  logic non_fatal_any;

  // First stage holds the reduced and masked status
  logic fatal_any_q;
  logic non_fatal_any_q;

  // Second stage drives the outputs
  logic all_fatal_q;
  logic all_non_fatal_q;

  //////////////////////////////////////////////////////////////////////
  // Masking and reduction
  //////////////////////////////////////////////////////////////////////

  // A set mask bit hides the status bit from the summary only
  // The status register itself still holds it
  assign fatal_any     = |(fatal_status_i & ~fatal_mask_i);
  assign non_fatal_any = |(non_fatal_status_i & ~non_fatal_mask_i);

  //////////////////////////////////////////////////////////////////////
  // Two register stages
  //////////////////////////////////////////////////////////////////////

  // A status change in cycle K shows on the outputs in cycle K+2
  // Both stages update every cycle, so back-to-back changes pipeline
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fatal_any_q     <= 1'b0;
      non_fatal_any_q <= 1'b0;
      all_fatal_q     <= 1'b0;
      all_non_fatal_q <= 1'b0;
    end else begin
      fatal_any_q     <= fatal_any;
      non_fatal_any_q <= non_fatal_any;
      all_fatal_q     <= fatal_any_q;
      all_non_fatal_q <= non_fatal_any_q;
    end
  end

  assign all_error_fatal_o     = all_fatal_q;
  assign all_error_non_fatal_o = all_non_fatal_q;

endmodule

/* logic/mci_err_status.sv */
`timescale 1ns/1ps

module mci_err_status #(
  // Payload layout as one of the hardware error vector types
  parameter type err_t = mci_pkg::hw_err_fatal_t
) (
  input  logic core_clk_i,
  input  logic rst_n_i,

  // Error sources with one bit per status field
  input  err_t src_i,

  // Write-one-to-clear pulses
  input  err_t clr_i,

  // Captured status as software reads it
  output err_t status_o
);

  err_t status_q;
  err_t status_d;

  //////////////////////////////////////////////////////////////////////
  // Sticky update
  //////////////////////////////////////////////////////////////////////

  // Clear first and then set, so a source that fires in the same cycle
  // as its clear keeps the bit set
  assign status_d = err_t'((status_q & ~clr_i) | src_i);

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign status_o = status_q;

endmodule

/* logic/mci_wdt.sv */
`timescale 1ns/1ps

module mci_wdt (
  input  logic              core_clk_i,
  input  logic              rst_n_i,

  // A low timer 2 enable selects cascade mode
  input  logic              timer1_en_i,
  input  logic              timer2_en_i,

  // Pets restart a running timer
  input  logic              timer1_restart_i,
  input  logic              timer2_restart_i,

  // Service pulses clear an expired timer
  input  logic              t1_service_i,
  input  logic              t2_service_i,

  input  mci_pkg::wdt_cnt_t timer1_period_i,
  input  mci_pkg::wdt_cnt_t timer2_period_i,

  output logic              t1_timeout_o,
  output logic              t2_timeout_o
);

  // Both timers live in two-entry arrays
  // Entry 0 is timer 1 and entry 1 is timer 2
  logic                    cascade_mode;
  logic [1:0]              cnt_en;
  logic [1:0]              restart;
  logic [1:0]              service;
  logic [1:0]              expire;
  logic [1:0]              timeout_q;
  mci_pkg::wdt_cnt_t [1:0] period;
  mci_pkg::wdt_cnt_t [1:0] count_q;

  //////////////////////////////////////////////////////////////////////
  // Mode select and per-timer controls
  //////////////////////////////////////////////////////////////////////

  assign cascade_mode = ~timer2_en_i;

  // Timer 1 runs whenever it is enabled
  assign cnt_en[0] = timer1_en_i;

  // In cascade mode timer 2 only starts once timer 1 has expired
  // and stays enabled
  assign cnt_en[1] = cascade_mode ? (timer1_en_i & timeout_q[0]) : 1'b1;

  assign restart[0] = timer1_restart_i;
  assign restart[1] = timer2_restart_i;

  assign service[0] = t1_service_i;
  assign service[1] = t2_service_i;

  assign period[0] = timer1_period_i;
  assign period[1] = timer2_period_i;

  // A timer expires when its counter reaches the period while it is
  // still running, so the flag is raised on the following edge
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      expire[i] = cnt_en[i] & ~timeout_q[i] & (count_q[i] == period[i]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters and timeout flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      timeout_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // A pet is only honoured while the timer has not expired
        // After expiry only a service brings the count back to zero
        if (service[i] || (restart[i] && !timeout_q[i])) begin
          count_q[i] <= '0;
        end else if (cnt_en[i] && !timeout_q[i]) begin
          count_q[i] <= count_q[i] + mci_pkg::wdt_cnt_t'(1);
        end

        // Timeout is a level held until serviced
        if (service[i]) begin
          timeout_q[i] <= 1'b0;
        end else if (expire[i]) begin
          timeout_q[i] <= 1'b1;
        end
      end
    end
  end

  assign t1_timeout_o = timeout_q[0];
  assign t2_timeout_o = timeout_q[1];

endmodule

/* logic/mci_pkg.sv */
`include "mci_config.svh"

package mci_pkg;

  //////////////////////////////////////////////////////////////////////
  // Watchdog types
  //////////////////////////////////////////////////////////////////////

  // Counter value and programmed period of one watchdog timer
  typedef logic [`MCI_WDT_CNT_W-1:0] wdt_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Hardware error vectors
  //////////////////////////////////////////////////////////////////////

  // Fatal status layout
  // The timer 2 expiry sits above the external sources
  typedef struct packed {
    logic                              wdt_t2;
    logic [`MCI_NUM_FATAL_EXT-1:0]     ext;
  } hw_err_fatal_t;

  // Non-fatal status layout
  // The timer 1 expiry sits above the external sources, so a first
  // watchdog expiry is only reported as non-fatal
  typedef struct packed {
    logic                              wdt_t1;
    logic [`MCI_NUM_NON_FATAL_EXT-1:0] ext;
  } hw_err_non_fatal_t;

endpackage

/* logic/mci_config.svh */
`ifndef MCI_CONFIG_SVH
`define MCI_CONFIG_SVH

// Watchdog sizing
// Both timer counters and both period inputs share this width
`define MCI_WDT_CNT_W 16

// Hardware error source counts
// These count only the external sources; the watchdog adds one bit
// to each status vector on top of them
`define MCI_NUM_FATAL_EXT 4

`define MCI_NUM_NON_FATAL_EXT 4

`endif
